//--- zhxpu_pkg.sv
package zhxpu_pkg;

	typedef logic [15:0] word_t;

	// Flash read access time in clock cycles
	localparam int FLASH_WAIT = 3;
	// SRAM strobe width in clock cycles
	localparam int SRAM_WAIT  = 2;
	localparam int BOOT_MAX   = 64;
	localparam int FLASH_AW   = 22;
	localparam int SRAM_AW    = 18;

	localparam word_t STATUS_ADDR = 16'hBF01;

	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		word_t adr;
		word_t dat;
	} wb_req_t;

	typedef struct packed {
		logic  ack;
		word_t dat;
	} wb_rsp_t;

	typedef enum logic [2:0] {
		BOOT_IDLE,
		BOOT_READ_LEN,
		BOOT_READ_WORD,
		BOOT_WRITE_WORD,
		BOOT_DONE
	} boot_state_t;

	typedef enum logic [1:0] {
		SRAM_IDLE,
		SRAM_ACCESS,
		SRAM_ACK
	} sram_state_t;

endpackage

//--- flash_reader.sv
`timescale 1ns/1ps

module flash_reader
	import zhxpu_pkg::*;
(
	input  logic                clk,
	input  logic                arst_n,
	input  logic                rd_req,
	input  word_t               rd_addr,
	output logic                rd_done,
	output word_t               rd_data,
	output logic [FLASH_AW-1:0] flash_addr,
	input  word_t               flash_data,
	output logic                flash_ce,
	output logic                flash_oe
);

	logic       busy;
	logic [3:0] wait_cnt;
	logic       start;
	logic       last_wait;

	assign start     = !busy && rd_req;
	assign last_wait = busy && (wait_cnt == 4'(FLASH_WAIT - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy     <= 1'b0;
			wait_cnt <= '0;
			rd_done  <= 1'b0;
			flash_ce <= 1'b1;
			flash_oe <= 1'b1;
		end else begin
			rd_done <= 1'b0;
			if (start) begin
				busy     <= 1'b1;
				wait_cnt <= '0;
				flash_ce <= 1'b0;
				flash_oe <= 1'b0;
			end else if (last_wait) begin
				// Data valid on the last wait cycle
				busy     <= 1'b0;
				flash_ce <= 1'b1;
				flash_oe <= 1'b1;
				rd_done  <= 1'b1;
			end else if (busy) begin
				wait_cnt <= wait_cnt + 4'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			flash_addr <= FLASH_AW'(rd_addr);
		end
		if (last_wait) begin
			rd_data <= flash_data;
		end
	end

endmodule

//--- bootloader.sv
`timescale 1ns/1ps

module bootloader
	import zhxpu_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	output logic    rd_req,
	output word_t   rd_addr,
	input  logic    rd_done,
	input  word_t   rd_data,
	output wb_req_t boot_wb,
	input  wb_rsp_t boot_rsp,
	output logic    boot_done,
	output word_t   boot_addr,
	output word_t   boot_count
);

	boot_state_t state;
	word_t       len_q;
	word_t       idx_q;
	word_t       len_lim;

	// Image length clipped to the copy limit
	assign len_lim = (rd_data > word_t'(BOOT_MAX)) ? word_t'(BOOT_MAX) : rd_data;

	// idx_q counts the words already written to SRAM
	assign boot_count = idx_q;
	assign boot_done  = (state == BOOT_DONE);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= BOOT_IDLE;
			len_q     <= '0;
			idx_q     <= '0;
			rd_req    <= 1'b0;
			rd_addr   <= '0;
			boot_wb   <= '0;
			boot_addr <= '0;
		end else begin
			rd_req <= 1'b0;
			case (state)
				BOOT_IDLE: begin
					rd_req  <= 1'b1;
					rd_addr <= '0;
					state   <= BOOT_READ_LEN;
				end
				BOOT_READ_LEN: begin
					if (rd_done) begin
						len_q <= len_lim;
						if (len_lim == '0) begin
							state <= BOOT_DONE;
						end else begin
							rd_req  <= 1'b1;
							rd_addr <= 16'd1;
							state   <= BOOT_READ_WORD;
						end
					end
				end
				BOOT_READ_WORD: begin
					if (rd_done) begin
						boot_wb.cyc <= 1'b1;
						boot_wb.stb <= 1'b1;
						boot_wb.we  <= 1'b1;
						boot_wb.adr <= idx_q;
						boot_wb.dat <= rd_data;
						state       <= BOOT_WRITE_WORD;
					end
				end
				BOOT_WRITE_WORD: begin
					if (boot_rsp.ack) begin
						boot_wb.cyc <= 1'b0;
						boot_wb.stb <= 1'b0;
						boot_wb.we  <= 1'b0;
						boot_addr   <= idx_q;
						idx_q       <= idx_q + 16'd1;
						if (idx_q + 16'd1 == len_q) begin
							state <= BOOT_DONE;
						end else begin
							// Flash word k+1 lands at SRAM address k
							rd_req  <= 1'b1;
							rd_addr <= idx_q + 16'd2;
							state   <= BOOT_READ_WORD;
						end
					end
				end
				BOOT_DONE: state <= BOOT_DONE;
				default:   state <= BOOT_IDLE;
			endcase
		end
	end

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
	import zhxpu_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	input  logic    boot_done,
	input  word_t   boot_count,
	input  wb_req_t boot_wb,
	output wb_rsp_t boot_rsp,
	input  wb_req_t cpu_wb,
	output wb_rsp_t cpu_rsp,
	output wb_req_t ram_wb,
	input  wb_rsp_t ram_rsp
);

	logic    cpu_status;
	logic    stat_ack;
	word_t   stat_dat;
	wb_req_t cpu_ram;

	assign cpu_status = cpu_wb.cyc && cpu_wb.stb && (cpu_wb.adr == STATUS_ADDR);

	// Status accesses never reach the SRAM
	always_comb begin
		cpu_ram = cpu_wb;
		if (cpu_wb.adr == STATUS_ADDR) begin
			cpu_ram.cyc = 1'b0;
			cpu_ram.stb = 1'b0;
		end
	end

	// CPU is locked out until the image is in place
	assign ram_wb = boot_done ? cpu_ram : boot_wb;

	always_comb begin
		boot_rsp.ack = ram_rsp.ack && !boot_done;
		boot_rsp.dat = ram_rsp.dat;
	end

	always_comb begin
		cpu_rsp.ack = stat_ack || (ram_rsp.ack && boot_done);
		cpu_rsp.dat = stat_ack ? stat_dat : ram_rsp.dat;
	end

	// One-cycle status ack, writes are dropped
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			stat_ack <= 1'b0;
		end else begin
			stat_ack <= boot_done && cpu_status && !stat_ack;
		end
	end

	always_ff @(posedge clk) begin
		stat_dat <= {boot_done, boot_count[14:0]};
	end

endmodule

//--- sram_ctrl.sv
`timescale 1ns/1ps

module sram_ctrl
	import zhxpu_pkg::*;
(
	input  logic               clk,
	input  logic               arst_n,
	input  wb_req_t            ram_wb,
	output wb_rsp_t            ram_rsp,
	output logic [SRAM_AW-1:0] ram_addr,
	output word_t              ram_dq_out,
	input  word_t              ram_dq_in,
	output logic               ram_dq_oe,
	output logic               ram_en,
	output logic               ram_oe,
	output logic               ram_we
);

	sram_state_t state;
	logic [3:0]  wait_cnt;
	logic        accept;
	logic        last_wait;
	word_t       rdata_q;

	assign accept    = (state == SRAM_IDLE) && ram_wb.cyc && ram_wb.stb;
	assign last_wait = (state == SRAM_ACCESS) && (wait_cnt == 4'(SRAM_WAIT - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= SRAM_IDLE;
			wait_cnt  <= '0;
			ram_en    <= 1'b1;
			ram_oe    <= 1'b1;
			ram_we    <= 1'b1;
			ram_dq_oe <= 1'b0;
		end else begin
			case (state)
				SRAM_IDLE: begin
					if (accept) begin
						state     <= SRAM_ACCESS;
						wait_cnt  <= '0;
						ram_en    <= 1'b0;
						ram_oe    <= ram_wb.we;
						ram_we    <= !ram_wb.we;
						ram_dq_oe <= ram_wb.we;
					end
				end
				SRAM_ACCESS: begin
					if (last_wait) begin
						state     <= SRAM_ACK;
						ram_en    <= 1'b1;
						ram_oe    <= 1'b1;
						ram_we    <= 1'b1;
						ram_dq_oe <= 1'b0;
					end else begin
						wait_cnt <= wait_cnt + 4'd1;
					end
				end
				// Master drops stb next cycle, so IDLE sees it low
				SRAM_ACK: state <= SRAM_IDLE;
				default:  state <= SRAM_IDLE;
			endcase
		end
	end

	// Address and data held from accept to the end of the strobe
	always_ff @(posedge clk) begin
		if (accept) begin
			ram_addr   <= SRAM_AW'(ram_wb.adr);
			ram_dq_out <= ram_wb.dat;
		end
		if (last_wait && !ram_oe) begin
			rdata_q <= ram_dq_in;
		end
	end

	always_comb begin
		ram_rsp.ack = (state == SRAM_ACK);
		ram_rsp.dat = rdata_q;
	end

endmodule

//--- progress_display.sv
`timescale 1ns/1ps

module progress_display
	import zhxpu_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  word_t      boot_addr,
	output logic [6:0] seg_hi,
	output logic [6:0] seg_lo
);

	// Active low, bit order g f e d c b a
	function automatic logic [6:0] hex_to_seg(input logic [3:0] digit);
		case (digit)
			4'h0:    return 7'h40;
			4'h1:    return 7'h79;
			4'h2:    return 7'h24;
			4'h3:    return 7'h30;
			4'h4:    return 7'h19;
			4'h5:    return 7'h12;
			4'h6:    return 7'h02;
			4'h7:    return 7'h78;
			4'h8:    return 7'h00;
			4'h9:    return 7'h10;
			4'hA:    return 7'h08;
			4'hB:    return 7'h03;
			4'hC:    return 7'h46;
			4'hD:    return 7'h21;
			4'hE:    return 7'h06;
			default: return 7'h0E;
		endcase
	endfunction

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			seg_hi <= hex_to_seg(4'h0);
			seg_lo <= hex_to_seg(4'h0);
		end else begin
			seg_hi <= hex_to_seg(boot_addr[7:4]);
			seg_lo <= hex_to_seg(boot_addr[3:0]);
		end
	end

endmodule

//--- zhxpu_boot.sv
`timescale 1ns/1ps

module zhxpu_boot
	import zhxpu_pkg::*;
(
	input  logic                clk,
	input  logic                arst_n,
	output logic [FLASH_AW-1:0] flash_addr,
	input  word_t               flash_data,
	output logic                flash_ce,
	output logic                flash_oe,
	output logic                flash_byte,
	output logic [SRAM_AW-1:0]  ram_addr,
	output word_t               ram_dq_out,
	input  word_t               ram_dq_in,
	output logic                ram_dq_oe,
	output logic                ram_en,
	output logic                ram_oe,
	output logic                ram_we,
	input  wb_req_t             cpu_wb,
	output wb_rsp_t             cpu_rsp,
	output logic                boot_done,
	output logic [6:0]          seg_hi,
	output logic [6:0]          seg_lo
);

	logic    rd_req;
	word_t   rd_addr;
	logic    rd_done;
	word_t   rd_data;
	wb_req_t boot_wb;
	wb_rsp_t boot_rsp;
	wb_req_t ram_wb;
	wb_rsp_t ram_rsp;
	word_t   boot_addr;
	word_t   boot_count;

	// Word mode
	assign flash_byte = 1'b1;

	flash_reader flash_reader_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.rd_req     (rd_req),
		.rd_addr    (rd_addr),
		.rd_done    (rd_done),
		.rd_data    (rd_data),
		.flash_addr (flash_addr),
		.flash_data (flash_data),
		.flash_ce   (flash_ce),
		.flash_oe   (flash_oe)
	);

	bootloader bootloader_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.rd_req     (rd_req),
		.rd_addr    (rd_addr),
		.rd_done    (rd_done),
		.rd_data    (rd_data),
		.boot_wb    (boot_wb),
		.boot_rsp   (boot_rsp),
		.boot_done  (boot_done),
		.boot_addr  (boot_addr),
		.boot_count (boot_count)
	);

	mem_arbiter mem_arbiter_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.boot_done  (boot_done),
		.boot_count (boot_count),
		.boot_wb    (boot_wb),
		.boot_rsp   (boot_rsp),
		.cpu_wb     (cpu_wb),
		.cpu_rsp    (cpu_rsp),
		.ram_wb     (ram_wb),
		.ram_rsp    (ram_rsp)
	);

	sram_ctrl sram_ctrl_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.ram_wb     (ram_wb),
		.ram_rsp    (ram_rsp),
		.ram_addr   (ram_addr),
		.ram_dq_out (ram_dq_out),
		.ram_dq_in  (ram_dq_in),
		.ram_dq_oe  (ram_dq_oe),
		.ram_en     (ram_en),
		.ram_oe     (ram_oe),
		.ram_we     (ram_we)
	);

	progress_display progress_display_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.boot_addr (boot_addr),
		.seg_hi    (seg_hi),
		.seg_lo    (seg_lo)
	);

endmodule

//--- tb_mem_models.sv
`timescale 1ns/1ps

// Read-only NOR flash, low 256 words populated
module flash_model
	import zhxpu_pkg::*;
(
	input  logic [FLASH_AW-1:0] flash_addr,
	input  logic                flash_ce,
	input  logic                flash_oe,
	input  logic                flash_byte,
	output word_t               flash_data
);

	word_t mem [256];

	assign flash_data = (!flash_ce && !flash_oe && flash_byte) ?
		mem[flash_addr[7:0]] : 16'hFFFF;

endmodule

// Asynchronous SRAM, 1K words
module sram_model
	import zhxpu_pkg::*;
(
	input  logic               clk,
	input  logic [SRAM_AW-1:0] ram_addr,
	input  word_t              ram_dq_out,
	output word_t              ram_dq_in,
	input  logic               ram_dq_oe,
	input  logic               ram_en,
	input  logic               ram_oe,
	input  logic               ram_we
);

	word_t mem [1024];

	// Write lands while en and we are both low
	always @(posedge clk) begin
		if (!ram_en && !ram_we && ram_dq_oe) begin
			mem[ram_addr[9:0]] <= ram_dq_out;
		end
	end

	assign ram_dq_in = (!ram_en && !ram_oe && !ram_dq_oe) ? mem[ram_addr[9:0]] : 16'h0000;

endmodule

//--- tb_zhxpu_boot_sva.sv
`timescale 1ns/1ps

module sram_ctrl_sva
	import zhxpu_pkg::*;
(
	input logic               clk,
	input logic               arst_n,
	input wb_rsp_t            ram_rsp,
	input logic [SRAM_AW-1:0] ram_addr,
	input word_t              ram_dq_out,
	input logic               ram_en,
	input logic               ram_oe,
	input logic               ram_we
);

	we_oe_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(!ram_we && !ram_oe))
		else $error("ram_we and ram_oe are low together");

	ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		ram_rsp.ack |=> !ram_rsp.ack)
		else $error("ack held for more than one cycle");

	// Pins steady for the whole strobe
	strobe_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(!ram_en && $past(!ram_en)) |-> ($stable(ram_addr) && $stable(ram_dq_out)))
		else $error("SRAM address or write data changed while ram_en low");

endmodule

bind sram_ctrl sram_ctrl_sva sram_ctrl_sva_i (
	.clk        (clk),
	.arst_n     (arst_n),
	.ram_rsp    (ram_rsp),
	.ram_addr   (ram_addr),
	.ram_dq_out (ram_dq_out),
	.ram_en     (ram_en),
	.ram_oe     (ram_oe),
	.ram_we     (ram_we)
);

//--- tb_zhxpu_boot.sv
`timescale 1ns/1ps

module tb_zhxpu_boot
	import zhxpu_pkg::*;
();

	localparam int NUM_REC     = 64;
	localparam int FLASH_WORDS = 256;
	localparam int SRAM_WORDS  = 1024;
	localparam int NUM_RAND    = 32;

	localparam logic [3:0] KIND_FLASH = 4'hF;
	localparam logic [3:0] KIND_WRITE = 4'h1;
	localparam logic [3:0] KIND_READ  = 4'h2;

	// Active low, bit order g f e d c b a
	localparam logic [6:0] SEG_TABLE [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
	};

	logic                clk = 1'b0;
	logic                arst_n;
	logic [FLASH_AW-1:0] flash_addr;
	word_t               flash_data;
	logic                flash_ce;
	logic                flash_oe;
	logic                flash_byte;
	logic [SRAM_AW-1:0]  ram_addr;
	word_t               ram_dq_out;
	word_t               ram_dq_in;
	logic                ram_dq_oe;
	logic                ram_en;
	logic                ram_oe;
	logic                ram_we;
	wb_req_t             cpu_wb;
	wb_rsp_t             cpu_rsp;
	logic                boot_done;
	logic [6:0]          seg_hi;
	logic [6:0]          seg_lo;

	logic [35:0] cases [NUM_REC];
	word_t       flash_ref [FLASH_WORDS];
	word_t       ram_ref [SRAM_WORDS];
	word_t       rand_addr [NUM_RAND];
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          limit = 0;
	int          seed;
	int          file_ops_n;
	int          boot_n;

	always #5 clk = ~clk;

	zhxpu_boot zhxpu_boot_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.flash_addr (flash_addr),
		.flash_data (flash_data),
		.flash_ce   (flash_ce),
		.flash_oe   (flash_oe),
		.flash_byte (flash_byte),
		.ram_addr   (ram_addr),
		.ram_dq_out (ram_dq_out),
		.ram_dq_in  (ram_dq_in),
		.ram_dq_oe  (ram_dq_oe),
		.ram_en     (ram_en),
		.ram_oe     (ram_oe),
		.ram_we     (ram_we),
		.cpu_wb     (cpu_wb),
		.cpu_rsp    (cpu_rsp),
		.boot_done  (boot_done),
		.seg_hi     (seg_hi),
		.seg_lo     (seg_lo)
	);

	flash_model flash_model_i (
		.flash_addr (flash_addr),
		.flash_ce   (flash_ce),
		.flash_oe   (flash_oe),
		.flash_byte (flash_byte),
		.flash_data (flash_data)
	);

	sram_model sram_model_i (
		.clk        (clk),
		.ram_addr   (ram_addr),
		.ram_dq_out (ram_dq_out),
		.ram_dq_in  (ram_dq_in),
		.ram_dq_oe  (ram_dq_oe),
		.ram_en     (ram_en),
		.ram_oe     (ram_oe),
		.ram_we     (ram_we)
	);

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	endtask

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("ERROR: timeout after %0d cycles, the DUT stopped answering", cycles);
			errors++;
			finish_run();
		end
	end

	task automatic expect_word(input string what, input word_t got, input word_t exp);
		checks++;
		assert (got == exp) else begin
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic drive_req(input logic we, input word_t adr, input word_t dat);
		cpu_wb.cyc = 1'b1;
		cpu_wb.stb = 1'b1;
		cpu_wb.we  = we;
		cpu_wb.adr = adr;
		cpu_wb.dat = dat;
	endtask

	// One Wishbone classic cycle, request released on the ack cycle
	task automatic bus_access(input logic we, input word_t adr, input word_t dat,
		output word_t rdat);
		@(negedge clk);
		drive_req(we, adr, dat);
		do begin
			@(negedge clk);
		end while (!cpu_rsp.ack);
		rdat   = cpu_rsp.dat;
		cpu_wb = '0;
	endtask

	task automatic load_memories();
		logic [3:0] kind;
		word_t      adr;
		word_t      dat;
		for (int i = 0; i < NUM_REC; i++) begin
			cases[i] = '0;
		end
		$readmemh("boot_cases.txt", cases);
		for (int a = 0; a < FLASH_WORDS; a++) begin
			flash_ref[a] = {~a[7:0], a[7:0]};
		end
		// Initial SRAM pattern, A5A5 at the first address past the boot limit
		for (int a = 0; a < SRAM_WORDS; a++) begin
			ram_ref[a] = 16'hA5A5 ^ word_t'(a - BOOT_MAX);
		end
		file_ops_n = 0;
		for (int i = 0; i < NUM_REC; i++) begin
			kind = cases[i][35:32];
			adr  = cases[i][31:16];
			dat  = cases[i][15:0];
			if (kind == KIND_FLASH) begin
				flash_ref[adr[7:0]] = dat;
			end else if (kind == KIND_WRITE || kind == KIND_READ) begin
				file_ops_n++;
			end
		end
		for (int a = 0; a < FLASH_WORDS; a++) begin
			flash_model_i.mem[a] = flash_ref[a];
		end
		for (int a = 0; a < SRAM_WORDS; a++) begin
			sram_model_i.mem[a] = ram_ref[a];
		end
		boot_n = (int'(flash_ref[0]) > BOOT_MAX) ? BOOT_MAX : int'(flash_ref[0]);
		// Flash word a+1 ends up at SRAM address a
		for (int a = 0; a < boot_n; a++) begin
			ram_ref[a] = flash_ref[a + 1];
		end
	endtask

	task automatic reset_state();
		expect_word("flash_ce in reset", word_t'(flash_ce), 16'h0001);
		expect_word("flash_oe in reset", word_t'(flash_oe), 16'h0001);
		expect_word("ram_en in reset", word_t'(ram_en), 16'h0001);
		expect_word("ram_oe in reset", word_t'(ram_oe), 16'h0001);
		expect_word("ram_we in reset", word_t'(ram_we), 16'h0001);
		expect_word("ram_dq_oe in reset", word_t'(ram_dq_oe), 16'h0000);
		expect_word("ack in reset", word_t'(cpu_rsp.ack), 16'h0000);
		expect_word("boot_done in reset", word_t'(boot_done), 16'h0000);
		expect_word("seg_hi in reset", word_t'(seg_hi), word_t'(SEG_TABLE[0]));
		expect_word("seg_lo in reset", word_t'(seg_lo), word_t'(SEG_TABLE[0]));
	endtask

	// CPU read held from the start of the boot
	task automatic boot_lockout();
		@(negedge clk);
		expect_word("boot_done at early read", word_t'(boot_done), 16'h0000);
		drive_req(1'b0, 16'h0000, 16'h0000);
		do begin
			@(negedge clk);
			if (!boot_done) begin
				expect_word("ack while boot_done low", word_t'(cpu_rsp.ack), 16'h0000);
			end
		end while (!cpu_rsp.ack);
		expect_word("boot_done at early read ack", word_t'(boot_done), 16'h0001);
		expect_word("early read of address 0", cpu_rsp.dat, flash_ref[1]);
		cpu_wb = '0;
	endtask

	task automatic display_digits();
		word_t last;
		last = word_t'(boot_n - 1);
		expect_word("seg_hi after boot", word_t'(seg_hi), word_t'(SEG_TABLE[last[7:4]]));
		expect_word("seg_lo after boot", word_t'(seg_lo), word_t'(SEG_TABLE[last[3:0]]));
	endtask

	task automatic image_copy();
		word_t rdat;
		for (int a = 0; a < boot_n; a++) begin
			bus_access(1'b0, word_t'(a), 16'h0000, rdat);
			expect_word($sformatf("image word %0d", a), rdat, flash_ref[a + 1]);
		end
	endtask

	task automatic length_limit();
		word_t rdat;
		bus_access(1'b0, STATUS_ADDR, 16'h0000, rdat);
		expect_word("status word", rdat, 16'h8000 | word_t'(boot_n));
		if (int'(flash_ref[0]) > BOOT_MAX) begin
			bus_access(1'b0, word_t'(BOOT_MAX), 16'h0000, rdat);
			expect_word("word past the boot limit", rdat, 16'hA5A5);
		end
	endtask

	task automatic file_ops();
		logic [3:0] kind;
		word_t      adr;
		word_t      dat;
		word_t      rdat;
		for (int i = 0; i < NUM_REC; i++) begin
			kind = cases[i][35:32];
			adr  = cases[i][31:16];
			dat  = cases[i][15:0];
			if (kind == KIND_WRITE) begin
				bus_access(1'b1, adr, dat, rdat);
				if (adr != STATUS_ADDR) begin
					ram_ref[adr[9:0]] = dat;
				end
			end else if (kind == KIND_READ) begin
				bus_access(1'b0, adr, 16'h0000, rdat);
				expect_word($sformatf("file read of %h", adr), rdat, dat);
				if (adr != STATUS_ADDR) begin
					expect_word($sformatf("reference at %h", adr), rdat, ram_ref[adr[9:0]]);
				end
			end
		end
	endtask

	task automatic random_traffic();
		word_t dat;
		word_t rdat;
		for (int i = 0; i < NUM_RAND; i++) begin
			rand_addr[i] = word_t'($random(seed)) & 16'h03FF;
			dat = word_t'($random(seed));
			bus_access(1'b1, rand_addr[i], dat, rdat);
			ram_ref[rand_addr[i][9:0]] = dat;
		end
		for (int i = 0; i < NUM_RAND; i++) begin
			bus_access(1'b0, rand_addr[i], 16'h0000, rdat);
			expect_word($sformatf("random read of %h", rand_addr[i]), rdat,
				ram_ref[rand_addr[i][9:0]]);
		end
	endtask

	initial begin
		seed   = 32;
		arst_n = 1'b0;
		cpu_wb = '0;
		load_memories();
		limit = boot_n * 12 + (file_ops_n + boot_n + 2 * NUM_RAND + 3) * 8 + 2000;
		repeat (10) @(negedge clk);
		reset_state();
		arst_n = 1'b1;
		boot_lockout();
		display_digits();
		image_copy();
		length_limit();
		file_ops();
		random_traffic();
		finish_run();
	end

endmodule

//--- boot_cases.txt
// Columns: kind (F flash word, 1 CPU write, 2 CPU read) _ address _ data or expected
// Flash word 0 is the image length, larger than the copy limit here
F_0000_0050
F_0001_1234
F_0002_BEEF
F_0003_0F0F
F_0010_C0DE
F_0040_7E57
F_0041_DEAD
1_0100_ABCD
1_0101_5555
2_0100_ABCD
2_0101_5555
2_0001_BEEF
2_003F_7E57
2_0040_A5A5
2_BF01_8040
1_BF01_0000
2_BF01_8040
1_0000_FFFF
2_0000_FFFF

//--- filelist.f
zhxpu_pkg.sv
flash_reader.sv
bootloader.sv
mem_arbiter.sv
sram_ctrl.sv
progress_display.sv
zhxpu_boot.sv
tb_mem_models.sv
tb_zhxpu_boot_sva.sv
tb_zhxpu_boot.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_zhxpu_boot
FILELIST = filelist.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TESTBENCH PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
